//--- common/icache_pkg.sv
package icache_pkg;

    // Byte address width seen by the core and the memory
    localparam int ADDR_W = 32;

    // Instruction word and memory beat width
    localparam int WORD_W = 32;

    // Address bits that pick a byte inside a word
    localparam int BYTE_OFFSET = 2;

    // Controller states
    //   ST_IDLE     lookups are taken, hits answered
    //   ST_REQUEST  memory request raised, beat counter cleared
    //   ST_FILL     block beats written as they arrive
    //   ST_RESPOND  requested word read out of the fresh block
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_REQUEST = 2'b01,
        ST_FILL    = 2'b10,
        ST_RESPOND = 2'b11
    } ctrl_state_t;

endpackage

//--- icache/data_array.sv
`timescale 1ns/1ps

module data_array import icache_pkg::*; #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int WAY_W = $clog2(NUM_WAYS),
    localparam int OFF_W = $clog2(BLOCK_WORDS)
) (
    input  logic              Clk,
    input  logic              MemDataReady,
    input  logic [WORD_W-1:0] MemDataIn,
    input  logic [SET_W-1:0]  fill_set,
    input  logic [WAY_W-1:0]  fill_way,
    input  logic [OFF_W-1:0]  beat_index,
    input  logic              rd_en,
    input  logic [SET_W-1:0]  rd_set,
    input  logic [WAY_W-1:0]  rd_way,
    input  logic [OFF_W-1:0]  rd_offset,
    output logic [WORD_W-1:0] Instruction
);

    localparam int IDX_W = SET_W + WAY_W + OFF_W;
    localparam int DEPTH = NUM_SETS * NUM_WAYS * BLOCK_WORDS;

    // One flat word array, indexed by set, way and word
    logic [WORD_W-1:0] mem [DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign wr_idx = {fill_set, fill_way, beat_index};
    assign rd_idx = {rd_set, rd_way, rd_offset};

    // Each refill beat lands as it arrives
    always_ff @(posedge Clk) begin
        if (MemDataReady) begin
            mem[wr_idx] <= MemDataIn;
        end
    end

    // Word held until the next read
    always_ff @(posedge Clk) begin
        if (rd_en) begin
            Instruction <= mem[rd_idx];
        end
    end

endmodule

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int WAY_W = $clog2(NUM_WAYS),
    localparam int OFF_W = $clog2(BLOCK_WORDS),
    localparam int TAG_W = ADDR_W - SET_W - OFF_W - BYTE_OFFSET
) (
    input  logic              Clk,
    input  logic              rst,
    input  logic              ReadEnable,
    input  logic [ADDR_W-1:0] ReadAddress,
    input  logic              hit,
    input  logic [WAY_W-1:0]  hit_way,
    input  logic [WAY_W-1:0]  victim_way,
    input  logic              last_beat,
    input  logic              MemDataReady,
    output logic              Ready,
    output logic              Busy,
    output logic [ADDR_W-1:0] MemReadAddress,
    output logic              MemReadRequest,
    output logic              start,
    output logic              fill_commit,
    output logic [SET_W-1:0]  fill_set,
    output logic [TAG_W-1:0]  fill_tag,
    output logic [OFF_W-1:0]  fill_offset,
    output logic [WAY_W-1:0]  fill_way,
    output logic              rd_en,
    output logic [SET_W-1:0]  rd_set,
    output logic [WAY_W-1:0]  rd_way,
    output logic [OFF_W-1:0]  rd_offset
);

    // Lowest address bit of the set index
    localparam int SET_LSB = BYTE_OFFSET + OFF_W;

    ctrl_state_t       state;
    logic [ADDR_W-1:0] miss_addr;
    logic [WAY_W-1:0]  victim_q;
    logic              lookup;
    logic              beat_taken;

    assign lookup     = (state == ST_IDLE) && ReadEnable && !Busy;
    assign beat_taken = (state == ST_FILL) && MemDataReady;

    // Fields of the outstanding miss
    assign fill_set    = miss_addr[SET_LSB +: SET_W];
    assign fill_tag    = miss_addr[ADDR_W-1:SET_LSB+SET_W];
    assign fill_offset = miss_addr[BYTE_OFFSET +: OFF_W];
    assign fill_way    = victim_q;

    assign MemReadAddress = {miss_addr[ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};

    assign start       = (state == ST_REQUEST);
    assign fill_commit = beat_taken && last_beat;

    // Hit reads come straight from the fetch address, refill answers from the latched miss
    assign rd_en     = (lookup && hit) || (state == ST_RESPOND);
    assign rd_set    = (state == ST_RESPOND) ? fill_set    : ReadAddress[SET_LSB +: SET_W];
    assign rd_way    = (state == ST_RESPOND) ? fill_way    : hit_way;
    assign rd_offset = (state == ST_RESPOND) ? fill_offset : ReadAddress[BYTE_OFFSET +: OFF_W];

    always_ff @(posedge Clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            Ready          <= 1'b0;
            Busy           <= 1'b0;
            MemReadRequest <= 1'b0;
        end else begin
            // Word is registered in the data array on the same edge
            Ready <= rd_en;
            case (state)
                ST_IDLE: begin
                    if (lookup && !hit) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    MemReadRequest <= 1'b1;
                    Busy           <= 1'b1;
                    state          <= ST_FILL;
                end
                ST_FILL: begin
                    if (fill_commit) begin
                        MemReadRequest <= 1'b0;
                        state          <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    Busy  <= 1'b0;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (lookup && !hit) begin
            miss_addr <= ReadAddress;
        end
        // Victim taken once fill_set points at the missing set
        if (state == ST_REQUEST) begin
            victim_q <= victim_way;
        end
    end

endmodule

//--- icache/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic              Clk,
    input  logic              rst,

    // Core fetch side
    input  logic              ReadEnable,
    input  logic [ADDR_W-1:0] ReadAddress,
    output logic [WORD_W-1:0] Instruction,
    output logic              Ready,
    output logic              Busy,

    // Memory controller side
    output logic [ADDR_W-1:0] MemReadAddress,
    output logic              MemReadRequest,
    input  logic [WORD_W-1:0] MemDataIn,
    input  logic              MemDataReady
);

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W = ADDR_W - SET_W - OFF_W - BYTE_OFFSET;

    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim_way;
    logic [NUM_WAYS-1:0] valid_bits;
    logic                start;
    logic                last_beat;
    logic [OFF_W-1:0]    beat_index;
    logic                fill_commit;
    logic [SET_W-1:0]    fill_set;
    logic [TAG_W-1:0]    fill_tag;
    logic [WAY_W-1:0]    fill_way;
    logic                rd_en;
    logic [SET_W-1:0]    rd_set;
    logic [WAY_W-1:0]    rd_way;
    logic [OFF_W-1:0]    rd_offset;

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_ctrl (
        .Clk            (Clk),
        .rst            (rst),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .last_beat      (last_beat),
        .MemDataReady   (MemDataReady),
        .Ready          (Ready),
        .Busy           (Busy),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .start          (start),
        .fill_commit    (fill_commit),
        .fill_set       (fill_set),
        .fill_tag       (fill_tag),
        .fill_offset    (),
        .fill_way       (fill_way),
        .rd_en          (rd_en),
        .rd_set         (rd_set),
        .rd_way         (rd_way),
        .rd_offset      (rd_offset)
    );

    refill_counter #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_counter (
        .Clk          (Clk),
        .rst          (rst),
        .start        (start),
        .MemDataReady (MemDataReady),
        .beat_index   (beat_index),
        .last_beat    (last_beat)
    );

    tag_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tags (
        .Clk         (Clk),
        .rst         (rst),
        .ReadAddress (ReadAddress),
        .fill_commit (fill_commit),
        .fill_set    (fill_set),
        .fill_way    (fill_way),
        .fill_tag    (fill_tag),
        .hit         (hit),
        .hit_way     (hit_way),
        .valid_bits  (valid_bits)
    );

    way_select #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_way_select (
        .Clk         (Clk),
        .rst         (rst),
        .fill_set    (fill_set),
        .valid_bits  (valid_bits),
        .fill_commit (fill_commit),
        .victim_way  (victim_way)
    );

    data_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_data (
        .Clk          (Clk),
        .MemDataReady (MemDataReady),
        .MemDataIn    (MemDataIn),
        .fill_set     (fill_set),
        .fill_way     (fill_way),
        .beat_index   (beat_index),
        .rd_en        (rd_en),
        .rd_set       (rd_set),
        .rd_way       (rd_way),
        .rd_offset    (rd_offset),
        .Instruction  (Instruction)
    );

endmodule

//--- icache/refill_counter.sv
`timescale 1ns/1ps

module refill_counter #(
    parameter int BLOCK_WORDS = 4,
    localparam int OFF_W = $clog2(BLOCK_WORDS)
) (
    input  logic             Clk,
    input  logic             rst,
    input  logic             start,
    input  logic             MemDataReady,
    output logic [OFF_W-1:0] beat_index,
    output logic             last_beat
);

    logic on_final;

    // Beats arrive in ascending word order
    assign on_final  = (beat_index == OFF_W'(BLOCK_WORDS - 1));
    assign last_beat = on_final && MemDataReady;

    always_ff @(posedge Clk) begin
        if (rst || start) begin
            beat_index <= '0;
        end else if (MemDataReady) begin
            if (on_final) begin
                beat_index <= '0;
            end else begin
                beat_index <= beat_index + 1'b1;
            end
        end
    end

endmodule

//--- icache/tag_array.sv
`timescale 1ns/1ps

module tag_array import icache_pkg::*; #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int WAY_W = $clog2(NUM_WAYS),
    localparam int OFF_W = $clog2(BLOCK_WORDS),
    localparam int TAG_W = ADDR_W - SET_W - OFF_W - BYTE_OFFSET
) (
    input  logic                Clk,
    input  logic                rst,
    input  logic [ADDR_W-1:0]   ReadAddress,
    input  logic                fill_commit,
    input  logic [SET_W-1:0]    fill_set,
    input  logic [WAY_W-1:0]    fill_way,
    input  logic [TAG_W-1:0]    fill_tag,
    output logic                hit,
    output logic [WAY_W-1:0]    hit_way,
    output logic [NUM_WAYS-1:0] valid_bits
);

    localparam int SET_LSB = BYTE_OFFSET + OFF_W;

    logic [TAG_W-1:0]    tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];

    logic [SET_W-1:0] look_set;
    logic [TAG_W-1:0] look_tag;

    assign look_set = ReadAddress[SET_LSB +: SET_W];
    assign look_tag = ReadAddress[ADDR_W-1:SET_LSB+SET_W];

    // Way selector needs the state of the set being refilled
    assign valid_bits = valid[fill_set];

    // All ways compared at once, lowest matching way reported
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid[look_set][w] && (tags[look_set][w] == look_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (fill_commit) begin
            // Line becomes visible only once the whole block is in
            tags[fill_set][fill_way]  <= fill_tag;
            valid[fill_set][fill_way] <= 1'b1;
        end
    end

endmodule

//--- icache/way_select.sv
`timescale 1ns/1ps

module way_select #(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int WAY_W = $clog2(NUM_WAYS)
) (
    input  logic                Clk,
    input  logic                rst,
    input  logic [SET_W-1:0]    fill_set,
    input  logic [NUM_WAYS-1:0] valid_bits,
    input  logic                fill_commit,
    output logic [WAY_W-1:0]    victim_way
);

    logic [WAY_W-1:0] rr_ptr [NUM_SETS];
    logic             set_full;

    assign set_full = &valid_bits;

    // Empty ways first, lowest index wins, else the set's pointer
    always_comb begin
        victim_way = rr_ptr[fill_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill_commit && set_full) begin
            // Only an eviction moves the pointer
            if (rr_ptr[fill_set] == WAY_W'(NUM_WAYS - 1)) begin
                rr_ptr[fill_set] <= '0;
            end else begin
                rr_ptr[fill_set] <= rr_ptr[fill_set] + 1'b1;
            end
        end
    end

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

    localparam int NUM_SETS     = 8;
    localparam int NUM_WAYS     = 4;
    localparam int BLOCK_WORDS  = 4;
    localparam int RESET_CYCLES = 16;

    // Memory contents are address XOR this word
    localparam logic [WORD_W-1:0] PATTERN    = 32'h5A3C_96E1;
    localparam logic [ADDR_W-1:0] BLOCK_MASK = ADDR_W'(BLOCK_WORDS * 4 - 1);

    // Cycle budgets, per fetch and for the whole run
    localparam int MISS_BUDGET     = 30;
    localparam int HIT_BUDGET      = 4;
    localparam int NUM_MISSES      = 9;
    localparam int NUM_HITS        = 14;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_MISSES * MISS_BUDGET
                                     + NUM_HITS * HIT_BUDGET + 120;

    logic              Clk;
    logic              rst;
    logic              ReadEnable;
    logic [ADDR_W-1:0] ReadAddress;
    logic [WORD_W-1:0] Instruction;
    logic              Ready;
    logic              Busy;
    logic [ADDR_W-1:0] MemReadAddress;
    logic              MemReadRequest;
    logic [WORD_W-1:0] MemDataIn;
    logic              MemDataReady;

    int   value_errors;
    int   other_failures;
    int   miss_count;
    logic req_prev;

    tb_clock #(
        .PERIOD       (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .Clk (Clk),
        .rst (rst)
    );

    icache_top #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) uut (
        .Clk            (Clk),
        .rst            (rst),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .Instruction    (Instruction),
        .Ready          (Ready),
        .Busy           (Busy),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady)
    );

    sdram_model #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .PATTERN     (PATTERN),
        .SEED        (16216)
    ) u_mem (
        .Clk            (Clk),
        .rst            (rst),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady)
    );

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return addr ^ PATTERN;
    endfunction

    // Blocks that all map to set 3, one per tag k
    function automatic logic [ADDR_W-1:0] set_block(input int k);
        return 32'h0004_0030 + ADDR_W'(k) * 32'h0000_1000;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t",
                     name, got, expected, $time);
        end
    endtask

    // Each rising edge of the memory request is one miss
    always @(negedge Clk) begin
        if (MemReadRequest && !req_prev) begin
            miss_count++;
        end
        req_prev = MemReadRequest;
    end

    task automatic fetch(input logic [ADDR_W-1:0] addr, input bit expect_miss);
        int misses_before;
        int cycles;
        bit req_seen;
        bit ready_seen;
        misses_before = miss_count;
        cycles        = 0;
        req_seen      = 1'b0;
        ready_seen    = 1'b0;
        @(posedge Clk);
        ReadEnable  <= 1'b1;
        ReadAddress <= addr;
        @(posedge Clk);
        ReadEnable <= 1'b0;
        while (!ready_seen && cycles < MISS_BUDGET) begin
            @(negedge Clk);
            cycles++;
            if (MemReadRequest && !req_seen) begin
                req_seen = 1'b1;
                check("MemReadAddress", MemReadAddress, addr & ~BLOCK_MASK);
                check("Busy", Busy, 1);
            end
            ready_seen = Ready;
        end
        if (!ready_seen) begin
            other_failures++;
            $display("No Ready for the fetch at 0x%08h within %0d cycles", addr, MISS_BUDGET);
        end else begin
            check("Instruction", Instruction, mem_word(addr));
            check("Busy", Busy, 0);
            if (!expect_miss) begin
                check("Ready latency", cycles, 1);
            end
        end
        check("miss count", miss_count - misses_before, expect_miss);
    endtask

    task automatic reset_state_and_first_miss();
        @(negedge Clk);
        while (rst) @(negedge Clk);
        check("Ready", Ready, 0);
        check("Busy", Busy, 0);
        check("MemReadRequest", MemReadRequest, 0);
        fetch(32'h0000_1008, 1'b1);
    endtask

    task automatic hits_after_fill(input logic [ADDR_W-1:0] base);
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            fetch(base + ADDR_W'(4 * i), 1'b0);
        end
    endtask

    // One new word per cycle, Ready held high throughout
    task automatic back_to_back_hits(input logic [ADDR_W-1:0] base);
        int misses_before;
        misses_before = miss_count;
        @(posedge Clk);
        ReadEnable  <= 1'b1;
        ReadAddress <= base;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            @(posedge Clk);
            if (i < BLOCK_WORDS - 1) begin
                ReadAddress <= base + ADDR_W'(4 * (i + 1));
            end else begin
                ReadEnable <= 1'b0;
            end
            @(negedge Clk);
            check("Ready", Ready, 1);
            check("Instruction", Instruction, mem_word(base + ADDR_W'(4 * i)));
        end
        @(negedge Clk);
        check("Ready", Ready, 0);
        check("miss count", miss_count - misses_before, 0);
    endtask

    task automatic fill_ways_of_set();
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch(set_block(k) + 32'hC, 1'b1);
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch(set_block(k), 1'b0);
        end
    endtask

    task automatic round_robin_eviction();
        // Set is full, pointer at way 0
        fetch(set_block(NUM_WAYS), 1'b1);
        for (int k = 1; k <= NUM_WAYS; k++) begin
            fetch(set_block(k) + 32'h4, 1'b0);
        end
        // Refill lands in way 1, which then pushes its block into way 2
        fetch(set_block(0), 1'b1);
        fetch(set_block(1), 1'b1);
        fetch(set_block(3), 1'b0);
        fetch(set_block(0) + 32'h8, 1'b0);
    endtask

    task automatic fetch_while_busy(input logic [ADDR_W-1:0] addr,
                                    input logic [ADDR_W-1:0] hit_addr,
                                    input logic [ADDR_W-1:0] miss_addr);
        int misses_before;
        int ready_count;
        int cycles;
        bit busy_seen;
        misses_before = miss_count;
        cycles        = 0;
        busy_seen     = 1'b0;
        @(posedge Clk);
        ReadEnable  <= 1'b1;
        ReadAddress <= addr;
        @(posedge Clk);
        ReadEnable <= 1'b0;
        while (!busy_seen && cycles < MISS_BUDGET) begin
            @(negedge Clk);
            cycles++;
            busy_seen = Busy;
        end
        if (!busy_seen) begin
            other_failures++;
            $display("Busy never rose for the miss at 0x%08h", addr);
        end else begin
            // Two strobes early in the refill
            @(posedge Clk);
            ReadEnable  <= 1'b1;
            ReadAddress <= hit_addr;
            @(posedge Clk);
            ReadEnable <= 1'b0;
            @(posedge Clk);
            ReadEnable  <= 1'b1;
            ReadAddress <= miss_addr;
            @(posedge Clk);
            ReadEnable <= 1'b0;
            ready_count = 0;
            for (int c = 0; c < MISS_BUDGET; c++) begin
                @(negedge Clk);
                if (Ready) begin
                    ready_count++;
                    check("Instruction", Instruction, mem_word(addr));
                    check("Busy", Busy, 0);
                end
            end
            check("Ready pulses", ready_count, 1);
        end
        check("miss count", miss_count - misses_before, 1);
    endtask

    initial begin
        ReadEnable     = 1'b0;
        ReadAddress    = '0;
        value_errors   = 0;
        other_failures = 0;
        miss_count     = 0;
        req_prev       = 1'b0;
        reset_state_and_first_miss();
        hits_after_fill(32'h0000_1000);
        back_to_back_hits(32'h0000_1000);
        fill_ways_of_set();
        round_robin_eviction();
        fetch_while_busy(32'h0008_0054, 32'h0000_1004, 32'h0009_0060);
        repeat (2) @(negedge Clk);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verif/sdram_model.sv
`timescale 1ns/1ps

module sdram_model import icache_pkg::*; #(
    parameter int                BLOCK_WORDS = 4,
    parameter logic [WORD_W-1:0] PATTERN     = '0,
    parameter int                SEED        = 1
) (
    input  logic              Clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] MemReadAddress,
    input  logic              MemReadRequest,
    output logic [WORD_W-1:0] MemDataIn,
    output logic              MemDataReady
);

    integer            seed;
    int                gap;
    logic [ADDR_W-1:0] base;

    initial begin
        seed         = SEED;
        MemDataIn    = '0;
        MemDataReady = 1'b0;
        forever begin
            @(posedge Clk);
            // Request level as it was just before this edge
            if (!rst && MemReadRequest) begin
                base = MemReadAddress;
                for (int b = 0; b < BLOCK_WORDS; b++) begin
                    // Beat interval of 1 to 4 cycles
                    gap = 1 + int'($unsigned($random(seed)) % 4);
                    repeat (gap - 1) begin
                        MemDataReady <= 1'b0;
                        @(posedge Clk);
                    end
                    MemDataIn    <= (base + ADDR_W'(4 * b)) ^ PATTERN;
                    MemDataReady <= 1'b1;
                    @(posedge Clk);
                end
                // Request drops on the edge that takes the last beat
                MemDataReady <= 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic Clk,
    output logic rst
);

    initial begin
        Clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            Clk = ~Clk;
        end
    end

    // Reset released on a rising edge like any other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clk);
        rst <= 1'b0;
    end

endmodule

//--- verilog.f
common/icache_pkg.sv
icache/refill_counter.sv
icache/tag_array.sv
icache/way_select.sv
icache/data_array.sv
icache/icache_ctrl.sv
icache/icache_top.sv
verif/tb_clock.sv
verif/sdram_model.sv
verif/icache_tb.sv
